// ==== tb.f ====
diad_isa_pkg.sv
diad_bus_pkg.sv
unified_mem.sv
mem_arbiter.sv
fetch_unit.sv
decode_execute.sv
mem_writeback.sv
diad_core.sv
diad_properties.sv
tb_diad.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_diad -o sim_diad

./obj_dir/sim_diad > sim.log 2>&1 || true
cat sim.log

if grep -qF "** PASS **" sim.log; then
    exit 0
fi
exit 1

// ==== tb_diad.sv ====
/* Testbench for the diad core. Loads each program through the loader port,
   runs it and compares the retire trace against an instruction-set model */
module tb_diad;
    timeunit 1ns;
    timeprecision 1ps;

    import diad_isa_pkg::*;
    import diad_bus_pkg::*;

    localparam int LOAD_TIMEOUT = 20;
    localparam int HALT_TIMEOUT = 4000;
    localparam int MODEL_STEPS  = 2000;

    logic     clk;
    logic     rst;
    logic     run;
    mem_req_t load_req;
    logic     load_gnt;
    retire_t  retire;
    logic     halted;

    word_t    img [MEM_WORDS];
    word_t    model_mem [MEM_WORDS];
    retire_t  exp_q [$];
    int       matched;
    integer   seed;

    diad_core dut0 (
        .clk(clk), .rst(rst), .run(run),
        .load_req(load_req), .load_gnt(load_gnt),
        .retire(retire), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got !== exp)
            stop_on_error($sformatf(
                "CHECK FAILED retire st/idx/addr/data got %h/%h/%h/%h exp %h/%h/%h/%h",
                got.is_store, got.idx, got.addr, got.data,
                exp.is_store, exp.idx, exp.addr, exp.data));
    endtask

    task automatic check_halted(input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("CHECK FAILED halted got %h expected %h", got, exp));
    endtask

    function automatic word_t enc_reg(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {op, rd, rs, rt, 4'h0};
    endfunction

    function automatic word_t enc_imm(opcode_t op, reg_idx_t rd, imm_t imm);
        return {op, rd, imm};
    endfunction

    // Address-dependent background so every word of the image differs
    function automatic void fill_background();
        for (int a = 0; a < MEM_WORDS; a++)
            img[a] = {8'(a), ~8'(a), 8'(a) ^ 8'h5a};
    endfunction

    // Instruction-set model: runs the image and queues the expected side effects
    function automatic void build_expected();
        word_t    regs [REG_COUNT];
        addr_t    pc;
        word_t    w;
        logic [7:0] op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    imm_ext;
        addr_t    ea;
        bit       done;
        exp_q.delete();
        for (int i = 0; i < REG_COUNT; i++)
            regs[i] = '0;
        for (int a = 0; a < MEM_WORDS; a++)
            model_mem[a] = img[a];
        pc = '0;
        done = 1'b0;
        for (int step = 0; step < MODEL_STEPS && !done; step++) begin
            w = model_mem[pc];
            op = w[23:16];
            rd = w[15:12];
            rs = w[11:8];
            rt = w[7:4];
            imm_ext = {{12{w[11]}}, w[11:0]};
            ea = regs[rs][7:0];
            pc = pc + 8'd1;
            case (op)
                8'h01: regs[rd] = regs[rs] + regs[rt];
                8'h02: regs[rd] = regs[rs] - regs[rt];
                8'h11: regs[rd] = regs[rd] + imm_ext;
                8'h20: regs[rd] = model_mem[ea];
                8'h21: model_mem[ea] = regs[rt];
                8'h30: if (regs[rd] == '0) pc = pc + imm_ext[7:0];
                8'hff: done = 1'b1;
                default: ;
            endcase
            if (op == 8'h01 || op == 8'h02 || op == 8'h11 || op == 8'h20)
                exp_q.push_back('{valid: 1'b1, is_store: 1'b0, idx: rd,
                                  addr: 8'h00, data: regs[rd]});
            else if (op == 8'h21)
                exp_q.push_back('{valid: 1'b1, is_store: 1'b1, idx: 4'h0,
                                  addr: ea, data: regs[rt]});
        end
        if (!done)
            $display("model ran out of steps before reaching HLT");
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Every word is held on the loader port until its grant
    task automatic load_image();
        int waited;
        for (int a = 0; a < MEM_WORDS; a++) begin
            load_req <= '{req: 1'b1, we: 1'b1, addr: addr_t'(a), wdata: img[a]};
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > LOAD_TIMEOUT)
                    stop_on_error("loader port never received a grant");
            end while (!load_gnt);
        end
        load_req <= '0;
    endtask

    task automatic run_program(input string name);
        int waited;
        apply_reset();
        build_expected();
        load_image();
        @(posedge clk);
        // Still low from reset, the core has not started
        check_halted(halted, 1'b0);
        run <= 1'b1;
        waited = 0;
        while (!halted) begin
            @(posedge clk);
            waited++;
            if (waited > HALT_TIMEOUT)
                stop_on_error({"core did not halt in program ", name});
        end
        // Quiet period in which no further retire may appear
        repeat (10) @(posedge clk);
        if (exp_q.size() != 0)
            stop_on_error({"expected retire events were missing in program ", name});
        check_halted(halted, 1'b1);
        run <= 1'b0;
        $display("program %s done, %0d events matched so far", name, matched);
    endtask

    // Comparison of the retire trace, sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst && retire.valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("retire event appeared with none expected");
            end else begin
                check_retire(retire, exp_q.pop_front());
                matched++;
            end
        end
    end

    initial begin
        rst = 1'b1;
        run = 1'b0;
        load_req = '0;
        matched = 0;
        seed = 79799;

        // Straight-line ALU work with forwarding and 24-bit wrap
        fill_background();
        img[0] = enc_imm(OP_ADDI, 1, 12'sd5);
        img[1] = enc_imm(OP_ADDI, 2, -12'sd3);
        img[2] = enc_reg(OP_ADD, 3, 1, 2);
        img[3] = enc_reg(OP_SUB, 4, 2, 1);
        img[4] = enc_reg(OP_SUB, 6, 0, 1);
        img[5] = enc_reg(OP_ADD, 7, 3, 6);
        img[6] = enc_imm(OP_ADDI, 5, 12'sd2047);
        for (int i = 0; i < 14; i++)
            img[7 + i] = enc_reg(OP_ADD, 5, 5, 5);
        img[21] = enc_imm(OP_HLT, 0, 12'sd0);
        run_program("alu");

        // Store, load and a dependent use of the loaded register
        fill_background();
        img[0] = enc_imm(OP_ADDI, 1, 12'sd192);
        img[1] = enc_imm(OP_ADDI, 2, 12'sh123);
        img[2] = enc_reg(OP_ST, 0, 1, 2);
        img[3] = enc_reg(OP_LD, 3, 1, 0);
        img[4] = enc_reg(OP_ADD, 4, 3, 3);
        img[5] = enc_imm(OP_ADDI, 1, 12'sd1);
        img[6] = enc_reg(OP_LD, 6, 1, 0);
        img[7] = enc_imm(OP_ADDI, 6, 12'sd1);
        img[8] = enc_reg(OP_ST, 0, 1, 6);
        img[9] = enc_imm(OP_HLT, 0, 12'sd0);
        run_program("load_use");

        // Count-down loop, a branch not taken and a taken skip
        fill_background();
        img[0]  = enc_imm(OP_ADDI, 1, 12'sd4);
        img[1]  = enc_imm(OP_ADDI, 2, 12'sd3);
        img[2]  = enc_imm(OP_ADDI, 1, -12'sd1);
        img[3]  = enc_imm(OP_BZ, 1, 12'sd1);
        img[4]  = enc_imm(OP_BZ, 0, -12'sd4);
        img[5]  = enc_imm(OP_ADDI, 3, 12'sd7);
        img[6]  = enc_imm(OP_BZ, 3, 12'sd1);
        img[7]  = enc_imm(OP_ADDI, 4, 12'sd1);
        img[8]  = enc_imm(OP_BZ, 0, 12'sd1);
        img[9]  = enc_imm(OP_ADDI, 9, 12'sd99);
        img[10] = enc_imm(OP_HLT, 0, 12'sd0);
        run_program("branch");

        // Random ALU, load and store mix on two base registers
        fill_background();
        img[0] = enc_imm(OP_ADDI, 1, 12'sd192);
        img[1] = enc_imm(OP_ADDI, 15, 12'sd213);
        for (int i = 0; i < 40; i++) begin
            int kind;
            reg_idx_t rd;
            reg_idx_t rs;
            reg_idx_t rt;
            reg_idx_t base;
            kind = {$random(seed)} % 5;
            rd   = reg_idx_t'(2 + {$random(seed)} % 13);
            rs   = reg_idx_t'({$random(seed)} % 16);
            rt   = reg_idx_t'({$random(seed)} % 16);
            base = ({$random(seed)} % 2) ? 4'd1 : 4'd15;
            case (kind)
                0: img[2 + i] = enc_reg(OP_ADD, rd, rs, rt);
                1: img[2 + i] = enc_reg(OP_SUB, rd, rs, rt);
                2: img[2 + i] = enc_imm(OP_ADDI, rd, imm_t'($random(seed)));
                3: img[2 + i] = enc_reg(OP_LD, rd, base, 4'd0);
                default: img[2 + i] = enc_reg(OP_ST, 4'd0, base, rt);
            endcase
        end
        img[42] = enc_imm(OP_HLT, 0, 12'sd0);
        run_program("random");

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== diad_properties.sv ====
/* Bus and trace rules of the diad core, bound into every diad_core instance */
module diad_properties (
    input logic                   clk,
    input logic                   rst,
    input diad_bus_pkg::mem_req_t load_req,
    input diad_bus_pkg::mem_req_t data_req,
    input diad_bus_pkg::mem_req_t fetch_req,
    input logic                   load_gnt,
    input logic                   data_gnt,
    input logic                   fetch_gnt,
    input diad_bus_pkg::retire_t  retire,
    input logic                   halted
);
    timeunit 1ns;
    timeprecision 1ps;

    // The memory has one port
    one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0({load_gnt, data_gnt, fetch_gnt}))
        else $error("more than one grant high");

    grant_has_req: assert property (@(posedge clk) disable iff (rst)
        (!load_gnt || load_req.req) && (!data_gnt || data_req.req) &&
        (!fetch_gnt || fetch_req.req))
        else $error("grant without request");

    quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !retire.valid)
        else $error("retire event after halt");

endmodule

bind diad_core diad_properties props0 (
    .clk(clk), .rst(rst),
    .load_req(load_req), .data_req(data_req), .fetch_req(fetch_req),
    .load_gnt(load_gnt), .data_gnt(data_gnt), .fetch_gnt(fetch_gnt),
    .retire(retire), .halted(halted)
);

// ==== diad_core.sv ====
/* Three-stage diad core with its unified memory. The loader port writes the
   program before run rises, retire and halted report progress */
module diad_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  diad_bus_pkg::mem_req_t load_req,
    output logic                   load_gnt,
    output diad_bus_pkg::retire_t  retire,
    output logic                   halted
);
    import diad_isa_pkg::*;
    import diad_bus_pkg::*;

    mem_req_t fetch_req;
    mem_req_t data_req;
    mem_req_t mem_req;
    word_t    rdata;
    logic     data_gnt;
    logic     fetch_gnt;
    logic     data_rvalid;
    logic     fetch_rvalid;
    logic     ivalid;
    addr_t    ipc;
    word_t    instr;
    logic     hold;
    logic     redirect;
    logic     halt_fetch;
    addr_t    target;
    exec_t    exec;
    logic     busy;
    logic     wb_we;
    reg_idx_t wb_idx;
    word_t    wb_data;

    unified_mem u_mem (.clk(clk), .req(mem_req), .rdata(rdata));

    mem_arbiter u_arb (
        .clk(clk), .rst(rst),
        .load_req(load_req), .data_req(data_req), .fetch_req(fetch_req),
        .mem_req(mem_req),
        .load_gnt(load_gnt), .data_gnt(data_gnt), .fetch_gnt(fetch_gnt),
        .data_rvalid(data_rvalid), .fetch_rvalid(fetch_rvalid)
    );

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .run(run),
        .fetch_gnt(fetch_gnt), .fetch_rvalid(fetch_rvalid), .rdata(rdata),
        .hold(hold), .redirect(redirect), .halt_fetch(halt_fetch), .target(target),
        .fetch_req(fetch_req), .ivalid(ivalid), .ipc(ipc), .instr(instr)
    );

    decode_execute u_dex (
        .clk(clk), .rst(rst),
        .ivalid(ivalid), .ipc(ipc), .instr(instr), .busy(busy),
        .wb_we(wb_we), .wb_idx(wb_idx), .wb_data(wb_data),
        .hold(hold), .redirect(redirect), .halt_fetch(halt_fetch),
        .target(target), .exec(exec)
    );

    mem_writeback u_mwb (
        .clk(clk), .rst(rst), .exec(exec),
        .data_gnt(data_gnt), .data_rvalid(data_rvalid), .rdata(rdata),
        .data_req(data_req), .busy(busy),
        .wb_we(wb_we), .wb_idx(wb_idx), .wb_data(wb_data),
        .retire(retire), .halted(halted)
    );

endmodule

// ==== mem_writeback.sv ====
/* Memory/writeback stage: issues load and store requests, writes registers
   back and reports every register write and store on the retire trace */
module mem_writeback (
    input  logic                   clk,
    input  logic                   rst,
    input  diad_isa_pkg::exec_t    exec,
    input  logic                   data_gnt,
    input  logic                   data_rvalid,
    input  diad_isa_pkg::word_t    rdata,
    output diad_bus_pkg::mem_req_t data_req,
    output logic                   busy,
    output logic                   wb_we,
    output diad_isa_pkg::reg_idx_t wb_idx,
    output diad_isa_pkg::word_t    wb_data,
    output diad_bus_pkg::retire_t  retire,
    output logic                   halted
);
    import diad_isa_pkg::*;
    import diad_bus_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_READ, DONE} wb_state_t;

    wb_state_t state;
    logic      take;
    logic      is_alu;
    logic      alu_v;
    logic      ld_done;
    logic      st_done;
    logic      st_q;
    reg_idx_t  rd_q;
    addr_t     addr_q;
    word_t     data_q;

    assign take   = exec.valid && state == IDLE;
    assign is_alu = exec.op == OP_ADD || exec.op == OP_SUB || exec.op == OP_ADDI;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            alu_v <= 1'b0;
        end else begin
            alu_v <= take && is_alu;
            case (state)
                IDLE: begin
                    if (take && (exec.op == OP_LD || exec.op == OP_ST))
                        state <= REQ;
                    else if (take && exec.op == OP_HLT)
                        state <= DONE;
                end
                REQ:       if (data_gnt) state <= st_q ? IDLE : WAIT_READ;
                WAIT_READ: if (data_rvalid) state <= IDLE;
                // HLT has passed, nothing leaves DONE
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            st_q   <= exec.op == OP_ST;
            rd_q   <= exec.rd;
            addr_q <= addr_t'(exec.result);
            data_q <= (exec.op == OP_ST) ? exec.sdata : exec.result;
        end
    end

    // A load completes with its read data, a store with its grant
    assign ld_done = state == WAIT_READ && data_rvalid;
    assign st_done = state == REQ && data_gnt && st_q;

    assign data_req = '{req: state == REQ, we: st_q, addr: addr_q, wdata: data_q};

    assign busy    = state != IDLE;
    assign halted  = state == DONE;
    assign wb_we   = alu_v || ld_done;
    assign wb_idx  = rd_q;
    assign wb_data = ld_done ? rdata : data_q;

    assign retire = '{valid: wb_we || st_done,
                      is_store: st_done,
                      idx: st_done ? reg_idx_t'(0) : rd_q,
                      addr: st_done ? addr_q : addr_t'(0),
                      data: wb_data};

endmodule

// ==== decode_execute.sv ====
/* Decode/execute stage: register file, operand forwarding, load-use interlock,
   ALU and branch resolution. Results leave registered in the exec struct */
module decode_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ivalid,
    input  diad_bus_pkg::addr_t    ipc,
    input  diad_isa_pkg::word_t    instr,
    input  logic                   busy,
    input  logic                   wb_we,
    input  diad_isa_pkg::reg_idx_t wb_idx,
    input  diad_isa_pkg::word_t    wb_data,
    output logic                   hold,
    output logic                   redirect,
    output logic                   halt_fetch,
    output diad_bus_pkg::addr_t    target,
    output diad_isa_pkg::exec_t    exec
);
    import diad_isa_pkg::*;
    import diad_bus_pkg::*;

    typedef enum logic {RUN, HALTED} de_state_t;

    de_state_t state;
    word_t     rf [REG_COUNT];
    instr_t    f;
    imm_t      imm;
    word_t     imm_ext;
    reg_idx_t  a_idx;
    logic      use_a;
    logic      use_b;
    word_t     a_val;
    word_t     b_val;
    word_t     result;
    logic      ex_alu;
    logic      load_use;
    logic      accept;
    logic      taken;
    logic      ex_valid;
    opcode_t   ex_op;
    reg_idx_t  ex_rd;
    word_t     ex_result;
    word_t     ex_sdata;

    // Newest copy of a register: exec result, then write-back, then the file
    function automatic word_t operand(reg_idx_t idx);
        if (ex_alu && ex_rd == idx)
            return ex_result;
        if (wb_we && wb_idx == idx)
            return wb_data;
        return rf[idx];
    endfunction

    assign f       = instr;
    assign imm     = instr[11:0];
    assign imm_ext = {{12{imm[11]}}, imm};

    // ADDI and BZ take their register operand from rd
    always_comb begin
        use_a = 1'b0;
        use_b = 1'b0;
        a_idx = f.rs;
        case (f.op)
            OP_ADD, OP_SUB, OP_ST: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            OP_ADDI, OP_BZ: begin
                use_a = 1'b1;
                a_idx = f.rd;
            end
            OP_LD: use_a = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        a_val = operand(a_idx);
        b_val = operand(f.rt);
    end

    assign ex_alu   = ex_valid && (ex_op == OP_ADD || ex_op == OP_SUB || ex_op == OP_ADDI);
    assign load_use = ex_valid && ex_op == OP_LD &&
                      ((use_a && a_idx == ex_rd) || (use_b && f.rt == ex_rd));

    assign hold       = busy || (ivalid && load_use);
    assign accept     = ivalid && !hold && state == RUN;
    assign halt_fetch = state == HALTED;
    assign taken      = f.op == OP_BZ && a_val == '0;

    always_comb begin
        case (f.op)
            OP_ADD:       result = a_val + b_val;
            OP_SUB:       result = a_val - b_val;
            OP_ADDI:      result = a_val + imm_ext;
            OP_LD, OP_ST: result = a_val;
            default:      result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RUN;
            redirect <= 1'b0;
            ex_valid <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++)
                rf[i] <= '0;
        end else begin
            if (wb_we)
                rf[wb_idx] <= wb_data;
            redirect <= accept && taken;
            // Exec keeps its contents while writeback is busy
            if (!busy)
                ex_valid <= accept;
            if (accept && f.op == OP_HLT)
                state <= HALTED;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && taken)
            target <= ipc + addr_t'(1) + addr_t'(imm);
        if (accept) begin
            ex_op     <= f.op;
            ex_rd     <= f.rd;
            ex_result <= result;
            // ST writes rt to the word addressed by rs
            ex_sdata  <= b_val;
        end
    end

    assign exec = '{valid: ex_valid, op: ex_op, rd: ex_rd, result: ex_result,
                    sdata: ex_sdata};

endmodule

// ==== fetch_unit.sv ====
/* Fetch stage: keeps the PC, has at most one instruction read outstanding and
   presents the returned word to decode/execute, parking it while held */
module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   fetch_gnt,
    input  logic                   fetch_rvalid,
    input  diad_isa_pkg::word_t    rdata,
    input  logic                   hold,
    input  logic                   redirect,
    input  logic                   halt_fetch,
    input  diad_bus_pkg::addr_t    target,
    output diad_bus_pkg::mem_req_t fetch_req,
    output logic                   ivalid,
    output diad_bus_pkg::addr_t    ipc,
    output diad_isa_pkg::word_t    instr
);
    import diad_bus_pkg::*;

    addr_t pc;
    addr_t pend_pc;
    logic  pending;
    logic  kill;
    logic  stopped;
    logic  buf_valid;
    addr_t buf_pc;
    word_t buf_instr;
    logic  rd_live;
    logic  issue;

    // Returned word that no redirect has cancelled
    assign rd_live = fetch_rvalid && !kill;
    assign issue   = run && !stopped && !halt_fetch && !pending && !buf_valid;

    assign fetch_req = '{req: issue, we: 1'b0, addr: pc, wdata: '0};

    assign ivalid = !redirect && (buf_valid || rd_live);
    assign ipc    = buf_valid ? buf_pc : pend_pc;
    assign instr  = buf_valid ? buf_instr : rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= '0;
            pending   <= 1'b0;
            kill      <= 1'b0;
            stopped   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (halt_fetch)
                stopped <= 1'b1;
            if (redirect)
                pc <= target;
            else if (fetch_gnt)
                pc <= pc + addr_t'(1);
            // A redirect marks the read in flight as stale
            if (fetch_gnt) begin
                pending <= 1'b1;
                kill    <= redirect;
            end else if (fetch_rvalid) begin
                pending <= 1'b0;
                kill    <= 1'b0;
            end else if (redirect && pending) begin
                kill <= 1'b1;
            end
            if (redirect)
                buf_valid <= 1'b0;
            else if (buf_valid)
                buf_valid <= hold;
            else if (rd_live && hold)
                buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_gnt)
            pend_pc <= pc;
        if (!buf_valid) begin
            buf_pc    <= pend_pc;
            buf_instr <= rdata;
        end
    end

endmodule

// ==== mem_arbiter.sv ====
/* Fixed-priority arbiter in front of the unified memory: loader, then data,
   then fetch. Steers the read strobe back to whoever issued the read */
module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  diad_bus_pkg::mem_req_t load_req,
    input  diad_bus_pkg::mem_req_t data_req,
    input  diad_bus_pkg::mem_req_t fetch_req,
    output diad_bus_pkg::mem_req_t mem_req,
    output logic                   load_gnt,
    output logic                   data_gnt,
    output logic                   fetch_gnt,
    output logic                   data_rvalid,
    output logic                   fetch_rvalid
);
    import diad_bus_pkg::*;

    // Owner of the read that is returning this cycle
    logic data_rd_q;
    logic fetch_rd_q;

    assign load_gnt  = load_req.req;
    assign data_gnt  = data_req.req && !load_req.req;
    assign fetch_gnt = fetch_req.req && !load_req.req && !data_req.req;

    always_comb begin
        mem_req = '0;
        if (load_gnt)
            mem_req = load_req;
        else if (data_gnt)
            mem_req = data_req;
        else if (fetch_gnt)
            mem_req = fetch_req;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_rd_q  <= 1'b0;
            fetch_rd_q <= 1'b0;
        end else begin
            data_rd_q  <= data_gnt && !data_req.we;
            fetch_rd_q <= fetch_gnt && !fetch_req.we;
        end
    end

    assign data_rvalid  = data_rd_q;
    assign fetch_rvalid = fetch_rd_q;

endmodule

// ==== unified_mem.sv ====
/* Single-port word memory shared by program, instructions and data.
   Writes land at the edge, reads return on rdata one cycle later */
module unified_mem (
    input  logic                   clk,
    input  diad_bus_pkg::mem_req_t req,
    output diad_bus_pkg::word_t    rdata
);
    import diad_bus_pkg::*;

    word_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (req.req) begin
            if (req.we)
                mem[req.addr] <= req.wdata;
            else
                rdata <= mem[req.addr];
        end
    end

endmodule

// ==== diad_bus_pkg.sv ====
/* Memory side of the diad core: addresses, requests to the unified memory and
   the retire trace that the core reports to the outside */
package diad_bus_pkg;

    // Memory words are the instruction set's words
    import diad_isa_pkg::word_t;
    export diad_isa_pkg::word_t;

    localparam int MEM_WORDS = 256;

    typedef logic [7:0] addr_t;

    // A requester keeps this stable until its grant is high
    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // One architectural side effect: a register write or a store
    typedef struct packed {
        logic                   valid;
        logic                   is_store;
        diad_isa_pkg::reg_idx_t idx;
        addr_t                  addr;
        word_t                  data;
    } retire_t;

endpackage

// ==== diad_isa_pkg.sv ====
/* Instruction set of the diad core: opcodes, instruction fields and the payload
   handed from decode/execute to memory/writeback */
package diad_isa_pkg;

    localparam int REG_COUNT = 16;

    typedef logic [23:0] word_t;
    typedef logic [3:0] reg_idx_t;
    typedef logic signed [11:0] imm_t;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h01,
        OP_SUB  = 8'h02,
        OP_ADDI = 8'h11,
        OP_LD   = 8'h20,
        OP_ST   = 8'h21,
        OP_BZ   = 8'h30,
        OP_HLT  = 8'hff
    } opcode_t;

    // Register form of an instruction word
    // ADDI and BZ reuse bits 11..0 as the immediate
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [3:0] spare;
    } instr_t;

    // Executed instruction on its way to memory/writeback
    // result holds the ALU value, or the address for LD and ST
    typedef struct packed {
        logic     valid;
        opcode_t  op;
        reg_idx_t rd;
        word_t    result;
        word_t    sdata;
    } exec_t;

endpackage
